// ==== hdl/character_buffer.sv ====
`timescale 1ns/1ns

module character_buffer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     wr_en,
    input  charbuf_pkg::char_entry_t wr_entry,
    input  logic                     read,
    output charbuf_pkg::char_entry_t out,
    output logic                     empty,
    output logic                     full,
    output logic                     overflow
);
    import charbuf_pkg::*;

    char_entry_t mem [buf_depth];

    buf_addr_t first_addr; // head, next to be read
    buf_addr_t last_addr;  // tail, next free slot
    logic [buf_addr_width:0] count;

    logic do_write;
    logic do_read;

    assign empty = (count == '0);
    assign full  = (count == (buf_addr_width + 1)'(buf_depth));

    assign do_write = wr_en & ~full;
    assign do_read  = read & ~empty;

    // head word always visible
    assign out = mem[first_addr];

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[last_addr] <= wr_entry;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            first_addr <= '0;
            last_addr  <= '0;
        end else begin
            if (do_write) begin
                last_addr <= last_addr + 1'b1; // wraps at depth
            end
            if (do_read) begin
                first_addr <= first_addr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (wr_en && full) begin
            overflow <= 1'b1; // sticky
        end
    end

endmodule

// ==== hdl/charbuf_pkg.sv ====
package charbuf_pkg;

    localparam int buf_depth = 32;
    localparam int buf_addr_width = 5;
    localparam int num_ports = 2;

    typedef logic [buf_addr_width-1:0] buf_addr_t;

    typedef struct packed {
        logic                source; // 0 for port 0, 1 for port 1
        ps2_pkg::ps2_code_t  code;
    } char_entry_t;

endpackage

// ==== hdl/ps2_dual_input.sv ====
`timescale 1ns/1ns

module ps2_dual_input (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [charbuf_pkg::num_ports-1:0]   ps2_clk,
    input  logic [charbuf_pkg::num_ports-1:0]   ps2_data,
    input  logic                                read,
    output charbuf_pkg::char_entry_t            out,
    output logic                                empty,
    output logic                                full,
    output logic                                overflow,
    output logic [ps2_pkg::err_count_width-1:0] err_count0,
    output logic [ps2_pkg::err_count_width-1:0] err_count1
);
    import ps2_pkg::*;
    import charbuf_pkg::*;

    ps2_frame_t           frame [num_ports];
    logic [num_ports-1:0] frame_done;
    logic                 wr_en;
    char_entry_t          wr_entry;

    ps2_frame_receiver rx0 (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk    (ps2_clk[0]),
        .ps2_data   (ps2_data[0]),
        .frame      (frame[0]),
        .frame_done (frame_done[0]),
        .err_count  (err_count0)
    );

    ps2_frame_receiver rx1 (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk    (ps2_clk[1]),
        .ps2_data   (ps2_data[1]),
        .frame      (frame[1]),
        .frame_done (frame_done[1]),
        .err_count  (err_count1)
    );

    write_arbiter arb0 (
        .clk        (clk),
        .reset      (reset),
        .frame      (frame),
        .frame_done (frame_done),
        .wr_en      (wr_en),
        .wr_entry   (wr_entry)
    );

    character_buffer buf0 (
        .clk        (clk),
        .reset      (reset),
        .wr_en      (wr_en),
        .wr_entry   (wr_entry),
        .read       (read),
        .out        (out),
        .empty      (empty),
        .full       (full),
        .overflow   (overflow)
    );

endmodule

// ==== hdl/ps2_frame_receiver.sv ====
`timescale 1ns/1ns

module ps2_frame_receiver (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                ps2_clk,
    input  logic                                ps2_data,
    output ps2_pkg::ps2_frame_t                 frame,
    output logic                                frame_done,
    output logic [ps2_pkg::err_count_width-1:0] err_count
);
    import ps2_pkg::*;

    logic [1:0] clk_sync;   // two-flop synchronizers
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       fall;
    logic       data_bit;

    logic [3:0] bit_cnt;
    logic       last_bit;
    logic       start_bit;
    logic       parity_bit;
    ps2_code_t  shift;
    logic       frame_good;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clk_sync  <= 2'b11; // lines idle high
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    assign fall     = clk_prev & ~clk_sync[1];
    assign data_bit = data_sync[1];
    assign last_bit = (bit_cnt == 4'(frame_bits - 1));

    // odd parity over data and parity bit, stop must be high
    assign frame_good = ~start_bit & (^{shift, parity_bit}) & data_bit;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bit_cnt    <= '0;
            frame_done <= 1'b0;
            frame      <= '0;
            err_count  <= '0;
        end else begin
            frame_done <= 1'b0;
            if (fall) begin
                if (last_bit) begin
                    bit_cnt        <= '0;
                    frame_done     <= 1'b1;
                    frame.code     <= shift;
                    frame.frame_ok <= frame_good;
                    if (!frame_good && err_count != '1) begin
                        err_count <= err_count + 1'b1; // saturates at all ones
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fall) begin
            if (bit_cnt == 4'd0) begin
                start_bit <= data_bit;
            end else if (bit_cnt <= 4'd8) begin
                shift <= {data_bit, shift[7:1]}; // lsb first
            end else if (bit_cnt == 4'd9) begin
                parity_bit <= data_bit;
            end
        end
    end

endmodule

// ==== hdl/ps2_pkg.sv ====
package ps2_pkg;

    // one frame is start, 8 data, parity, stop
    localparam int frame_bits = 11;

    // saturating bad-frame counter per port
    localparam int err_count_width = 8;

    // raw data byte as it came off the wire
    typedef logic [7:0] ps2_code_t;

    typedef struct packed {
        ps2_code_t code;
        logic      frame_ok; // start, parity and stop all good
    } ps2_frame_t;

endpackage

// ==== hdl/write_arbiter.sv ====
`timescale 1ns/1ns

module write_arbiter (
    input  logic                                     clk,
    input  logic                                     reset,
    input  ps2_pkg::ps2_frame_t                      frame [charbuf_pkg::num_ports],
    input  logic [charbuf_pkg::num_ports-1:0]        frame_done,
    output logic                                     wr_en,
    output charbuf_pkg::char_entry_t                 wr_entry
);
    import charbuf_pkg::*;

    logic [num_ports-1:0] pending;
    logic [num_ports-1:0] capture;
    char_entry_t          held [num_ports];
    logic                 prio;  // port that wins a tie
    logic                 grant;

    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            capture[i] = frame_done[i] & frame[i].frame_ok;
        end
    end

    always_comb begin
        if (pending[0] && pending[1]) begin
            grant = prio;
        end else begin
            grant = pending[1];
        end
    end

    assign wr_en    = |pending;
    assign wr_entry = held[grant];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pending <= '0;
            prio    <= 1'b0;
        end else begin
            if (wr_en) begin
                pending[grant] <= 1'b0;
                prio           <= ~grant; // other port next time
            end
            for (int i = 0; i < num_ports; i++) begin
                if (capture[i]) begin
                    pending[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_ports; i++) begin
            if (capture[i]) begin
                held[i].source <= 1'(i);
                held[i].code   <= frame[i].code;
            end
        end
    end

endmodule

// ==== ps2_dual_input.f ====
hdl/ps2_pkg.sv
hdl/charbuf_pkg.sv
hdl/ps2_frame_receiver.sv
hdl/write_arbiter.sv
hdl/character_buffer.sv
hdl/ps2_dual_input.sv
+incdir+sim
sim/ps2_dual_input_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the PS/2 dual input testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal \
    --top-module ps2_dual_input_tb \
    -f ps2_dual_input.f \
    -o ps2_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ps2_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "TEST FAILED" "$SIM_LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0

// ==== sim/ps2_tb_tasks.svh ====
`ifndef PS2_TB_TASKS_SVH
`define PS2_TB_TASKS_SVH

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h8020_0003;
    end
    return state >> 1;
endfunction

// one lfsr step per bit
function automatic logic [7:0] random_byte();
    logic [7:0] value;
    value = '0;
    for (int i = 0; i < 8; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        value = {value[6:0], lfsr_state[0]};
    end
    return value;
endfunction

task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
endtask

task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                     input string what);
    if (actual !== expected) begin
        $display("FAIL at %0t ns: %s, got 0x%0h, expected 0x%0h",
                 $time, what, actual, expected);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    end
endtask

// device side of one frame, start bit goes out first
task automatic send_frame(input int port, input logic [7:0] code,
                          input logic bad_parity, input logic bad_stop);
    logic [10:0] bits;
    logic        parity;
    parity = ~^code ^ bad_parity; // odd parity over data and parity bit
    bits   = {~bad_stop, parity, code, 1'b0};
    wait_cycles(1);
    for (int i = 0; i < $bits(bits); i++) begin
        ps2_data[port] <= bits[i]; // data moves while clock is high
        wait_cycles(half_period);
        ps2_clk[port] <= 1'b0;
        wait_cycles(half_period);
        ps2_clk[port] <= 1'b1;
    end
    wait_cycles(half_period);
    ps2_data[port] <= 1'b1;
    wait_cycles(2 * half_period); // idle gap between frames
endtask

`endif

// ==== sim/ps2_dual_input_tb.sv ====
`timescale 1ns/1ns

module ps2_dual_input_tb;
    import ps2_pkg::*;
    import charbuf_pkg::*;

    localparam int          half_period  = 5;  // system cycles per ps2 clock phase
    localparam int          reset_cycles = 16;
    localparam logic [31:0] lfsr_seed    = 32'hc8273ac0;
    localparam int          wait_limit   = 64;
    // 79 frames of about 126 cycles plus reads and resets, roughly doubled
    localparam int          timeout_cycles = 20000;

    logic                       clk;
    logic                       reset;
    logic [num_ports-1:0]       ps2_clk;
    logic [num_ports-1:0]       ps2_data;
    logic                       read;
    char_entry_t                out;
    logic                       empty;
    logic                       full;
    logic                       overflow;
    logic [err_count_width-1:0] err_count0;
    logic [err_count_width-1:0] err_count1;

    logic [31:0] lfsr_state = lfsr_seed;
    int          cycle_count = 0;

    `include "ps2_tb_tasks.svh"

    ps2_dual_input dut0 (
        .clk        (clk),
        .reset      (reset),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .read       (read),
        .out        (out),
        .empty      (empty),
        .full       (full),
        .overflow   (overflow),
        .err_count0 (err_count0),
        .err_count1 (err_count1)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        reset    <= 1'b1;
        read     <= 1'b0;
        ps2_clk  <= '1; // both lines idle high
        ps2_data <= '1;
        wait_cycles(reset_cycles);
        reset <= 1'b0;
        @(negedge clk);
        check(32'(empty), 32'd1, "empty after reset");
        check(32'(full), 32'd0, "full after reset");
        check(32'(overflow), 32'd0, "overflow after reset");
    endtask

    task automatic wait_not_empty();
        int n;
        n = 0;
        @(negedge clk);
        while (empty && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (empty) begin
            $display("no entry reached the buffer within %0d cycles", wait_limit);
            $display("TEST FAILED");
            $fatal(1, "buffer stayed empty");
        end
    endtask

    // entry is {source, code}
    task automatic pop_and_check(input logic [8:0] expected);
        @(negedge clk);
        check(32'(empty), 32'd0, "buffer empty before read");
        check(32'(out), 32'(expected), "head entry");
        @(posedge clk);
        read <= 1'b1;
        @(posedge clk);
        read <= 1'b0;
    endtask

    task automatic single_byte();
        send_frame(0, 8'h1c, 1'b0, 1'b0);
        wait_not_empty();
        pop_and_check({1'b0, 8'h1c});
        @(negedge clk);
        check(32'(empty), 32'd1, "empty after single read");
    endtask

    task automatic simultaneous_arrival();
        apply_reset(); // port 0 wins the first tie
        fork
            send_frame(0, 8'ha5, 1'b0, 1'b0);
            send_frame(1, 8'h3c, 1'b0, 1'b0);
        join
        wait_not_empty();
        pop_and_check({1'b0, 8'ha5});
        pop_and_check({1'b1, 8'h3c});
        @(negedge clk);
        check(32'(empty), 32'd1, "empty after both reads");
    endtask

    task automatic bad_frames();
        logic [err_count_width-1:0] base0;
        logic [err_count_width-1:0] base1;
        base0 = err_count0;
        base1 = err_count1;
        for (int p = 0; p < num_ports; p++) begin
            send_frame(p, 8'h5a, 1'b1, 1'b0); // wrong parity
            send_frame(p, 8'hc3, 1'b0, 1'b1); // stop bit low
        end
        @(negedge clk);
        check(32'(empty), 32'd1, "bad frames stored");
        check(32'(err_count0), 32'(base0) + 32'd2, "err_count0");
        check(32'(err_count1), 32'(base1) + 32'd2, "err_count1");
    endtask

    task automatic full_and_overflow();
        logic [7:0] code;
        logic [8:0] expected_q[$];
        for (int i = 0; i < buf_depth + 1; i++) begin
            code = random_byte();
            if (i < buf_depth) begin
                expected_q.push_back({1'b1, code});
            end
            send_frame(1, code, 1'b0, 1'b0);
            if (i == buf_depth - 1) begin
                @(negedge clk);
                check(32'(full), 32'd1, "full after 32 writes");
                check(32'(overflow), 32'd0, "overflow before 33rd write");
            end
        end
        @(negedge clk);
        check(32'(full), 32'd1, "full after 33 writes");
        check(32'(overflow), 32'd1, "overflow after 33 writes");
        while (expected_q.size() > 0) begin
            pop_and_check(expected_q.pop_front());
        end
        @(negedge clk);
        check(32'(empty), 32'd1, "empty after draining");
    endtask

    // pointers sit at 2 here, so 40 entries cross the wrap
    task automatic wraparound_random();
        logic [7:0] code;
        logic       src;
        logic [8:0] expected_q[$];
        for (int i = 0; i < 40; i++) begin
            src  = 1'(i % 2);
            code = random_byte();
            expected_q.push_back({src, code});
            send_frame(int'(src), code, 1'b0, 1'b0);
            @(negedge clk);
            while (!empty) begin
                check(32'(expected_q.size() > 0), 32'd1, "unexpected entry in buffer");
                pop_and_check(expected_q.pop_front());
                @(negedge clk);
            end
        end
        check(32'(expected_q.size()), 32'd0, "entries never read back");
    endtask

    initial begin
        reset    = 1'b1;
        read     = 1'b0;
        ps2_clk  = '1;
        ps2_data = '1;
        apply_reset();
        single_byte();
        simultaneous_arrival();
        bad_frames();
        full_and_overflow();
        wraparound_random();
        wait_cycles(4);
        $display("TEST PASSED");
        $finish;
    end

endmodule
